// File: Bender.yml
package:
  name: pipe_cpu

sources:
  - cpu_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - pipeline_tracker.sv
  - pipe_cpu.sv
  - target: test
    files:
      - trace_checker.sv
      - tb_pipe_cpu.sv

// File: all.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipeline_tracker.sv
pipe_cpu.sv
trace_checker.sv
tb_pipe_cpu.sv

// File: cpu_pkg.sv
// Fixed sizes for a four-register 8-bit core; data addresses wrap at 16 bytes, PC at 256.
package cpu_pkg;

    //////////////////////////////////////////////////
    // Widths and sizes.
    //////////////////////////////////////////////////
    localparam int data_w      = 8;    // Data path width.
    localparam int instr_w     = 16;   // Instruction word.
    localparam int pc_w        = 8;    // 256 instructions at most.
    localparam int reg_cnt     = 4;    // Register file entries.
    localparam int reg_aw      = 2;    // Register address bits.
    localparam int op_w        = 4;    // Opcode field.
    localparam int imm_w       = 8;    // I-type immediate.
    localparam int dmem_depth  = 16;   // Data memory bytes.
    localparam int dmem_aw     = 4;    // Low address bits used.
    localparam int seq_w       = 8;    // Sequence number, wraps around.
    localparam int stall_cnt_w = 3;    // Stall count, saturates at 7.

    // Tracker record: seq, pc, instr, stalls, in that order.
    localparam int rec_w = seq_w + pc_w + instr_w + stall_cnt_w;

    //////////////////////////////////////////////////
    // Instruction set.
    //////////////////////////////////////////////////
    typedef enum logic [op_w-1:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_addi = 4'd3,   // rd = rs + imm.
        op_ld   = 4'd4,   // rd = mem[rs + imm].
        op_st   = 4'd5,   // mem[rs + imm] = rd.
        op_nop  = 4'd14,
        op_hlt  = 4'd15   // Stops fetch.
    } op_t;

    // Register-register layout.
    typedef struct packed {
        op_t               op;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] rs;
        logic [reg_aw-1:0] rt;
        logic [5:0]        unused;   // Ignored by decode.
    } r_fmt_t;

    // Register-immediate layout.
    typedef struct packed {
        op_t               op;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] rs;
        logic [imm_w-1:0]  imm;
    } i_fmt_t;

    // One word, two views; opcode, rd and rs sit at the same bits in both.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

// File: decode_stage.sv
// No forwarding: a RAW hazard on execute or memory stalls here; write-back is passed through.
module decode_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        f_valid,
    input  logic [cpu_pkg::instr_w-1:0] f_instr,
    input  logic                        wb_we,     // Already qualified by wb_valid.
    input  logic [cpu_pkg::reg_aw-1:0]  wb_rd,
    input  logic [cpu_pkg::data_w-1:0]  wb_data,
    input  logic                        e_valid,
    input  logic                        e_we,
    input  logic [cpu_pkg::reg_aw-1:0]  e_rd,
    output logic                        stall,
    output logic                        halt_seen,
    output logic                        d_valid,
    output cpu_pkg::op_t                d_op,
    output logic [cpu_pkg::reg_aw-1:0]  d_rd,
    output logic [cpu_pkg::data_w-1:0]  d_a,       // rs value.
    output logic [cpu_pkg::data_w-1:0]  d_b,       // rt value, or rd for ST.
    output logic [cpu_pkg::imm_w-1:0]   d_imm,
    output logic                        d_we
);
    import cpu_pkg::*;

    instr_u            instr;
    op_t               op;
    logic              is_r;            // R view selected.
    logic [reg_aw-1:0] src_a;
    logic [reg_aw-1:0] src_b;
    logic              use_a;
    logic              use_b;
    logic              busy_a;          // src_a still to be written ahead.
    logic              busy_b;          // src_b still to be written ahead.
    logic              writes;
    logic              dec_valid;
    logic              accept;          // Instruction leaves decode this cycle.
    logic [data_w-1:0] rf [reg_cnt];
    logic [data_w-1:0] val_a;
    logic [data_w-1:0] val_b;

    //////////////////////////////////////////////////
    // Union decode.
    //////////////////////////////////////////////////
    assign instr  = instr_u'(f_instr);
    assign op     = instr.r.op;
    assign is_r   = op inside {op_add, op_sub, op_and};
    assign src_a  = instr.i.rs;                      // Same bits in both views.
    assign src_b  = is_r ? instr.r.rt : instr.i.rd;  // ST reads rd as store data.
    assign use_a  = is_r || op inside {op_addi, op_ld, op_st};
    assign use_b  = is_r || op == op_st;
    assign writes = is_r || op inside {op_addi, op_ld};

    // Register reads, with same-cycle write-back passed through.
    assign val_a = (wb_we && wb_rd == src_a) ? wb_data : rf[src_a];
    assign val_b = (wb_we && wb_rd == src_b) ? wb_data : rf[src_b];

    //////////////////////////////////////////////////
    // Hazard and issue.
    //////////////////////////////////////////////////
    // A valid instruction in execute or memory will write the source.
    assign busy_a = (d_valid && d_we && d_rd == src_a) ||
                    (e_valid && e_we && e_rd == src_a);
    assign busy_b = (d_valid && d_we && d_rd == src_b) ||
                    (e_valid && e_we && e_rd == src_b);

    assign dec_valid = f_valid && !halt_seen;  // Word behind HLT is ignored.
    assign stall     = dec_valid && ((use_a && busy_a) || (use_b && busy_b));
    assign accept    = dec_valid && !stall;

    // Register file, written at the end of write-back.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_cnt; i++) begin
                rf[i] <= '0;                   // Registers start at zero.
            end
        end else if (wb_we) begin
            rf[wb_rd] <= wb_data;
        end
    end

    // Halt flag, sticky until reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt_seen <= 1'b0;
        end else if (accept && op == op_hlt) begin
            halt_seen <= 1'b1;
        end
    end

    // Decode-to-execute register; a stall sends a bubble.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        d_op  <= op;
        d_rd  <= instr.i.rd;
        d_a   <= val_a;
        d_b   <= val_b;
        d_imm <= is_r ? '0 : instr.i.imm;    // R type has no immediate.
        d_we  <= writes;
    end

endmodule

// File: execute_stage.sv
// Single-cycle ALU, never stalls; ADDI, LD and ST all form rs + imm with 8-bit wrap.
module execute_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       d_valid,
    input  cpu_pkg::op_t               d_op,
    input  logic [cpu_pkg::reg_aw-1:0] d_rd,
    input  logic [cpu_pkg::data_w-1:0] d_a,
    input  logic [cpu_pkg::data_w-1:0] d_b,
    input  logic [cpu_pkg::imm_w-1:0]  d_imm,
    input  logic                       d_we,
    output logic                       e_valid,
    output cpu_pkg::op_t               e_op,
    output logic [cpu_pkg::reg_aw-1:0] e_rd,
    output logic [cpu_pkg::data_w-1:0] e_result,      // ALU value or memory address.
    output logic [cpu_pkg::data_w-1:0] e_store_data,
    output logic                       e_we
);
    import cpu_pkg::*;

    logic [data_w-1:0] alu;

    always_comb begin
        case (d_op)
            op_add:  alu = d_a + d_b;
            op_sub:  alu = d_a - d_b;
            op_and:  alu = d_a & d_b;
            default: alu = d_a + d_imm;   // Address adder; harmless for NOP and HLT.
        endcase
    end

    // Execute-to-memory register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        e_op         <= d_op;
        e_rd         <= d_rd;
        e_result     <= alu;
        e_store_data <= d_b;              // rd value for ST.
        e_we         <= d_we;
    end

endmodule

// File: fetch_stage.sv
// Instruction memory is read combinationally in the same cycle; PC wraps after 256 words.
module fetch_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,      // Hold PC and decode register.
    input  logic                        halt_seen,  // HLT left decode, stop for good.
    output logic [cpu_pkg::pc_w-1:0]    imem_addr,
    input  logic [cpu_pkg::instr_w-1:0] imem_data,
    output logic                        f_valid,
    output logic [cpu_pkg::pc_w-1:0]    f_pc,
    output logic [cpu_pkg::instr_w-1:0] f_instr
);
    import cpu_pkg::*;

    logic [pc_w-1:0] pc;
    logic            advance;

    assign advance   = !stall && !halt_seen;  // Fetch only when decode can take it.
    assign imem_addr = pc;

    // PC and valid bit.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= '0;
            f_valid <= 1'b0;
        end else if (halt_seen) begin
            f_valid <= 1'b0;               // Drops the word fetched behind HLT.
        end else if (advance) begin
            pc      <= pc + 1'b1;
            f_valid <= 1'b1;
        end
    end

    // Fetch-to-decode payload, held during a stall.
    always_ff @(posedge clk) begin
        if (advance) begin
            f_pc    <= pc;
            f_instr <= imem_data;
        end
    end

endmodule

// File: memory_stage.sv
// 16-byte data memory cleared at reset; only the low 4 address bits are decoded.
module memory_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       e_valid,
    input  cpu_pkg::op_t               e_op,
    input  logic [cpu_pkg::reg_aw-1:0] e_rd,
    input  logic [cpu_pkg::data_w-1:0] e_result,
    input  logic [cpu_pkg::data_w-1:0] e_store_data,
    input  logic                       e_we,
    output logic                       wb_valid,
    output cpu_pkg::op_t               wb_op,
    output logic                       wb_we,        // Valid and writing.
    output logic [cpu_pkg::reg_aw-1:0] wb_rd,
    output logic [cpu_pkg::data_w-1:0] wb_data
);
    import cpu_pkg::*;

    logic [data_w-1:0]  dmem [dmem_depth];
    logic [dmem_aw-1:0] addr;

    assign addr = e_result[dmem_aw-1:0];   // Upper address bits ignored.

    // Store port.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (e_valid && e_op == op_st) begin
            dmem[addr] <= e_store_data;
        end
    end

    // Memory-to-write-back register, control part.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= e_valid;
            wb_we    <= e_valid && e_we;   // Register file write enable.
        end
    end

    // Load data or ALU result.
    always_ff @(posedge clk) begin
        wb_op   <= e_op;
        wb_rd   <= e_rd;
        wb_data <= (e_op == op_ld) ? dmem[addr] : e_result;
    end

endmodule

// File: pipe_cpu.sv
// Five-stage core with no branches; imem_data must answer imem_addr in the same cycle.
module pipe_cpu (
    input  logic                            clk,
    input  logic                            rst_n,
    output logic [cpu_pkg::pc_w-1:0]        imem_addr,
    input  logic [cpu_pkg::instr_w-1:0]     imem_data,
    output logic                            trace_valid,
    output logic [cpu_pkg::seq_w-1:0]       trace_seq,
    output logic [cpu_pkg::pc_w-1:0]        trace_pc,
    output logic [cpu_pkg::instr_w-1:0]     trace_instr,
    output logic [cpu_pkg::stall_cnt_w-1:0] trace_stalls,
    output logic                            trace_we,
    output logic [cpu_pkg::reg_aw-1:0]      trace_rd,
    output logic [cpu_pkg::data_w-1:0]      trace_data,
    output logic                            halted
);
    import cpu_pkg::*;

    // Fetch to decode.
    logic               f_valid;
    logic [pc_w-1:0]    f_pc;
    logic [instr_w-1:0] f_instr;
    logic               stall;
    logic               halt_seen;
    // Decode to execute.
    logic               d_valid;
    op_t                d_op;
    logic [reg_aw-1:0]  d_rd;
    logic [data_w-1:0]  d_a;
    logic [data_w-1:0]  d_b;
    logic [imm_w-1:0]   d_imm;
    logic               d_we;
    // Execute to memory.
    logic               e_valid;
    op_t                e_op;
    logic [reg_aw-1:0]  e_rd;
    logic [data_w-1:0]  e_result;
    logic [data_w-1:0]  e_store_data;
    logic               e_we;
    // Write-back.
    logic               wb_valid;
    op_t                wb_op;
    logic               wb_we;
    logic [reg_aw-1:0]  wb_rd;
    logic [data_w-1:0]  wb_data;

    fetch_stage i_fetch (
        .clk, .rst_n, .stall, .halt_seen, .imem_addr, .imem_data,
        .f_valid, .f_pc, .f_instr
    );

    decode_stage i_decode (
        .clk, .rst_n, .f_valid, .f_instr, .wb_we, .wb_rd, .wb_data,
        .e_valid, .e_we, .e_rd, .stall, .halt_seen,
        .d_valid, .d_op, .d_rd, .d_a, .d_b, .d_imm, .d_we
    );

    execute_stage i_execute (
        .clk, .rst_n, .d_valid, .d_op, .d_rd, .d_a, .d_b, .d_imm, .d_we,
        .e_valid, .e_op, .e_rd, .e_result, .e_store_data, .e_we
    );

    memory_stage i_memory (
        .clk, .rst_n, .e_valid, .e_op, .e_rd, .e_result, .e_store_data, .e_we,
        .wb_valid, .wb_op, .wb_we, .wb_rd, .wb_data
    );

    // Observes fetch and write-back only.
    pipeline_tracker i_tracker (
        .clk, .rst_n, .f_valid, .f_pc, .f_instr, .stall, .halt_seen,
        .wb_valid, .wb_op, .wb_we, .wb_rd, .wb_data,
        .trace_valid, .trace_seq, .trace_pc, .trace_instr, .trace_stalls,
        .trace_we, .trace_rd, .trace_data, .halted
    );

endmodule

// File: pipeline_tracker.sv
// Sequence numbers count instructions leaving decode and wrap at 256; stall counts stop at 7.
module pipeline_tracker (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            f_valid,
    input  logic [cpu_pkg::pc_w-1:0]        f_pc,
    input  logic [cpu_pkg::instr_w-1:0]     f_instr,
    input  logic                            stall,
    input  logic                            halt_seen,
    input  logic                            wb_valid,
    input  cpu_pkg::op_t                    wb_op,
    input  logic                            wb_we,
    input  logic [cpu_pkg::reg_aw-1:0]      wb_rd,
    input  logic [cpu_pkg::data_w-1:0]      wb_data,
    output logic                            trace_valid,   // One pulse per retire.
    output logic [cpu_pkg::seq_w-1:0]       trace_seq,
    output logic [cpu_pkg::pc_w-1:0]        trace_pc,
    output logic [cpu_pkg::instr_w-1:0]     trace_instr,
    output logic [cpu_pkg::stall_cnt_w-1:0] trace_stalls,
    output logic                            trace_we,
    output logic [cpu_pkg::reg_aw-1:0]      trace_rd,
    output logic [cpu_pkg::data_w-1:0]      trace_data,
    output logic                            halted
);
    import cpu_pkg::*;

    logic [seq_w-1:0]       seq_cnt;     // Number of the instruction in decode.
    logic [stall_cnt_w-1:0] dec_stalls;  // Cycles it has been held so far.
    logic                   accept;
    logic [rec_w-1:0]       ex_rec;      // Shadow of execute.
    logic [rec_w-1:0]       mem_rec;     // Shadow of memory.
    logic [rec_w-1:0]       wb_rec;      // Shadow of write-back.

    // Same rule as decode: leaves when valid, not halted, not stalled.
    assign accept = f_valid && !halt_seen && !stall;

    //////////////////////////////////////////////////
    // Decode slot.
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq_cnt    <= '0;
            dec_stalls <= '0;
        end else if (accept) begin
            seq_cnt    <= seq_cnt + 1'b1;   // Wraps.
            dec_stalls <= '0;               // Next instruction starts clean.
        end else if (stall && dec_stalls != '1) begin
            dec_stalls <= dec_stalls + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Shadow pipeline, moving in step with the CPU.
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        ex_rec  <= {seq_cnt, f_pc, f_instr, dec_stalls};  // Bubble when not accepted.
        mem_rec <= ex_rec;
        wb_rec  <= mem_rec;
    end

    // Join record and write-back values.
    assign trace_valid = wb_valid;
    assign {trace_seq, trace_pc, trace_instr, trace_stalls} = wb_rec;
    assign trace_we   = wb_we;
    assign trace_rd   = wb_we ? wb_rd : '0;     // Zero for ST, NOP and HLT.
    assign trace_data = wb_we ? wb_data : '0;

    // Halted follows the HLT record by one cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (wb_valid && wb_op == op_hlt) begin
            halted <= 1'b1;
        end
    end

endmodule

// File: tb_pipe_cpu.sv
// Runs four programs, each after its own reset; the random one runs past the PC wrap, so seq wraps.
module tb_pipe_cpu;
    import cpu_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic [pc_w-1:0]        imem_addr;
    logic [instr_w-1:0]     imem_data;
    logic                   trace_valid;
    logic [seq_w-1:0]       trace_seq;
    logic [pc_w-1:0]        trace_pc;
    logic [instr_w-1:0]     trace_instr;
    logic [stall_cnt_w-1:0] trace_stalls;
    logic                   trace_we;
    logic [reg_aw-1:0]      trace_rd;
    logic [data_w-1:0]      trace_data;
    logic                   halted;
    logic [instr_w-1:0]     imem [256];
    logic [15:0]            lfsr_state;
    int                     late_hlt_addr = -1;  // HLT slot filled on the second pass only.
    int                     cycle_cnt   = 0;
    int                     cycle_limit = 0;   // Zero until the programs are sized.
    int                     total_instr = 0;
    int                     err_total;

    assign imem_data = imem[imem_addr];   // Combinational instruction memory.

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
    end
    always #2 clk = ~clk;

    pipe_cpu i_pipe_cpu (.*);
    trace_checker i_trace_checker (.*);

    //////////////////////////////////////////////////
    // Stimulus helpers.
    //////////////////////////////////////////////////
    function automatic logic lfsr_bit();
        logic fb;
        fb = ^(lfsr_state & 16'hB400);            // Taps 16, 14, 13, 11.
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) v = (v << 1) | lfsr_bit();
        return v;
    endfunction

    function automatic logic [15:0] r_word(input logic [3:0] op, input int rd, rs, rt);
        return {op, 2'(rd), 2'(rs), 2'(rt), 6'b0};
    endfunction

    function automatic logic [15:0] i_word(input logic [3:0] op, input int rd, rs, imm);
        return {op, 2'(rd), 2'(rs), 8'(imm)};
    endfunction

    function automatic logic [15:0] random_instr();
        int sel;
        sel = rand_bits(3);
        if (sel < 3) return r_word(4'(sel), rand_bits(2), rand_bits(2), rand_bits(2));
        if (sel < 6) return i_word(4'(sel), rand_bits(2), rand_bits(2), rand_bits(8));
        return {op_nop, 12'b0};                   // 6 and 7 become NOP.
    endfunction

    task automatic load_program(input int p);
        late_hlt_addr = -1;
        for (int a = 0; a < 256; a++) begin
            imem[a] = i_word(op_addi, 0, 0, a);  // Filler that would trace if fetched.
        end
        case (p)
            0: begin   // Independent ALU work.
                imem[0] = i_word(op_addi, 1, 0, 5);
                imem[1] = i_word(op_addi, 2, 0, 9);
                imem[2] = i_word(op_addi, 3, 0, 200);
                imem[3] = {op_nop, 12'b0};
                imem[4] = r_word(op_sub, 0, 1, 2);
                imem[5] = r_word(op_and, 1, 2, 3);
                imem[6] = {op_hlt, 12'b0};
            end
            1: begin   // Distance one, then distance two.
                imem[0] = i_word(op_addi, 1, 0, 3);
                imem[1] = r_word(op_add, 2, 1, 1);
                imem[2] = i_word(op_addi, 0, 0, 4);
                imem[3] = {op_nop, 12'b0};
                imem[4] = r_word(op_add, 3, 0, 2);
                imem[5] = {op_hlt, 12'b0};
            end
            2: begin   // Store then load, same address.
                imem[0] = i_word(op_addi, 1, 0, 8'h5A);
                imem[1] = i_word(op_addi, 2, 0, 6);
                imem[2] = i_word(op_st, 1, 2, 3);
                imem[3] = i_word(op_ld, 3, 2, 3);
                imem[4] = {op_nop, 12'b0};
                imem[5] = i_word(op_ld, 0, 0, 9);
                imem[6] = {op_hlt, 12'b0};
            end
            default: begin   // Random body; HLT lands at 200 on the second pass.
                lfsr_state    = 16'd38307;
                late_hlt_addr = 200;
                for (int a = 0; a < 200; a++) imem[a] = random_instr();
            end
        endcase
    endtask

    function automatic int program_length();
        for (int a = 0; a < 256; a++) begin
            if (imem[a][15:12] == op_hlt) return a + 1;
        end
        return 256;
    endfunction

    //////////////////////////////////////////////////
    // ISA model with the issue rule for stalls.
    //////////////////////////////////////////////////
    function automatic void model_program();
        logic [7:0]  regs [4];
        logic [7:0]  mem [16];
        int          wr_issue [4];   // Cycle each register's last producer left decode.
        int          last_issue;
        int          issue;
        int          stalls;
        int          a;
        logic [15:0] w;
        logic [3:0]  op;
        logic [1:0]  rd;
        logic [1:0]  rs;
        logic [1:0]  rt;
        logic [7:0]  val;
        logic        we;
        logic [7:0]  seq;
        for (int r = 0; r < 4; r++) begin
            regs[r]     = '0;
            wr_issue[r] = -100;
        end
        foreach (mem[k]) mem[k] = '0;
        last_issue = -1;
        seq        = '0;
        for (int n = 0; n < 512; n++) begin
            a  = n % 256;                      // PC wraps with the word count.
            w  = (n >= 256 && a == late_hlt_addr) ? {op_hlt, 12'b0} : imem[a];
            op = w[15:12];
            rd = w[11:10];
            rs = w[9:8];
            rt = w[7:6];
            issue = last_issue + 1;            // Arrival in decode.
            if (op <= op_st) issue = (wr_issue[rs] + 3 > issue) ? wr_issue[rs] + 3 : issue;
            if (op <= op_and) issue = (wr_issue[rt] + 3 > issue) ? wr_issue[rt] + 3 : issue;
            if (op == op_st) issue = (wr_issue[rd] + 3 > issue) ? wr_issue[rd] + 3 : issue;
            stalls = issue - last_issue - 1;
            stalls = (stalls > 7) ? 7 : stalls;  // Counter saturates.
            we  = op <= op_ld && op != op_st;
            val = '0;
            case (op)
                op_add:  val = regs[rs] + regs[rt];
                op_sub:  val = regs[rs] - regs[rt];
                op_and:  val = regs[rs] & regs[rt];
                op_addi: val = regs[rs] + w[7:0];
                op_ld:   val = mem[4'(regs[rs] + w[7:0])];
                op_st:   mem[4'(regs[rs] + w[7:0])] = regs[rd];
                default: val = '0;
            endcase
            if (we) begin
                regs[rd]     = val;
                wr_issue[rd] = issue;
            end
            i_trace_checker.push_expected({seq, 8'(a), w, 3'(stalls)},
                                          {we, we ? rd : 2'b0, val});
            last_issue = issue;
            seq++;
            if (op == op_hlt) break;
        end
    endfunction

    task automatic run_program(input int p);
        @(posedge clk);
        rst_n <= 1'b0;
        load_program(p);
        i_trace_checker.clear_expected();
        model_program();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        if (late_hlt_addr >= 0) begin
            do @(negedge clk); while (imem_addr != '1);   // First pass is past the slot.
            imem[late_hlt_addr] = {op_hlt, 12'b0};
        end
        do @(negedge clk); while (!halted);   // Halted is stable here.
        repeat (5) @(posedge clk);             // Catch anything retiring late.
    endtask

    // Run limit from the program sizes.
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the CPU did not halt within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        for (int p = 0; p < 4; p++) begin
            load_program(p);
            total_instr += program_length() + late_hlt_addr + 1;
        end
        cycle_limit = 8 * total_instr + 100;
        for (int p = 0; p < 4; p++) run_program(p);
        err_total = i_trace_checker.value_errs + i_trace_checker.extra_errs +
                    i_trace_checker.missing_errs + i_trace_checker.late_errs;
        $display("Errors: %0d value, %0d extra, %0d missing, %0d after halt",
                 i_trace_checker.value_errs, i_trace_checker.extra_errs,
                 i_trace_checker.missing_errs, i_trace_checker.late_errs);
        if (err_total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: trace_checker.sv
// Expects records in retire order; the queues must be refilled after every CPU reset.
module trace_checker (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            trace_valid,
    input  logic [cpu_pkg::seq_w-1:0]       trace_seq,
    input  logic [cpu_pkg::pc_w-1:0]        trace_pc,
    input  logic [cpu_pkg::instr_w-1:0]     trace_instr,
    input  logic [cpu_pkg::stall_cnt_w-1:0] trace_stalls,
    input  logic                            trace_we,
    input  logic [cpu_pkg::reg_aw-1:0]      trace_rd,
    input  logic [cpu_pkg::data_w-1:0]      trace_data,
    input  logic                            halted
);
    import cpu_pkg::*;

    logic [rec_w-1:0]        exp_rec_q [$];   // seq, pc, instr, stalls.
    logic [reg_aw+data_w:0]  exp_wb_q [$];    // we, rd, data.
    logic                    halted_q;
    int                      value_errs   = 0;
    int                      extra_errs   = 0;
    int                      missing_errs = 0;
    int                      late_errs    = 0;

    // Called by the testbench's reference model.
    function automatic void push_expected(input logic [rec_w-1:0] rec,
                                          input logic [reg_aw+data_w:0] wb);
        exp_rec_q.push_back(rec);
        exp_wb_q.push_back(wb);
    endfunction

    function automatic void clear_expected();
        exp_rec_q.delete();
        exp_wb_q.delete();
    endfunction

    //////////////////////////////////////////////////
    // Compare each retire against the queue head.
    //////////////////////////////////////////////////
    always @(posedge clk) begin : compare
        logic [rec_w-1:0]       rec;
        logic [reg_aw+data_w:0] wb;
        if (!rst_n) begin
            halted_q <= 1'b0;
        end else begin
            halted_q <= halted;
            if (trace_valid && halted) begin
                late_errs++;                                  // Nothing may retire now.
                $display("Trace record seq %0d came out after the CPU had halted", trace_seq);
            end else if (trace_valid && exp_rec_q.size() == 0) begin
                extra_errs++;
                $display("Extra trace record seq %0d pc %0d that the program does not have",
                         trace_seq, trace_pc);
            end else if (trace_valid) begin
                rec = exp_rec_q.pop_front();
                wb  = exp_wb_q.pop_front();
                if ({trace_seq, trace_pc, trace_instr, trace_stalls} !== rec ||
                    {trace_we, trace_rd, trace_data} !== wb) begin
                    value_errs++;
                    $display("error at %0t: got seq %0d pc %0d instr %h stalls %0d",
                             $time, trace_seq, trace_pc, trace_instr, trace_stalls);
                    $display("error at %0t: got we %b rd %0d data %h, expected %h / %h",
                             $time, trace_we, trace_rd, trace_data, rec, wb);
                end
            end
            // Rising halted means the HLT record was the last one.
            if (halted && !halted_q && exp_rec_q.size() != 0) begin
                missing_errs += exp_rec_q.size();
                $display("%0d expected trace records never came out before the CPU halted",
                         exp_rec_q.size());
            end
        end
    end

endmodule
